// File: src/shadow_cfg.svh
`ifndef SHADOW_CFG_SVH
`define SHADOW_CFG_SVH

////////////////////
// widths

// csr data and irq vector width
`define SHADOW_XLEN             32

// retire order number carried with each record
`define SHADOW_ORDER_W          16

////////////////////
// pipeline

// IF, ID, EX and WB
`define SHADOW_PIPE_DEPTH       4

// memory accesses the core can have in flight
`define SHADOW_LSU_DEPTH        2

////////////////////
// csr map

`define SHADOW_CSR_MSTATUS      12'h300
`define SHADOW_CSR_MIE          12'h304
`define SHADOW_MSTATUS_MIE_BIT  3

`endif

// File: src/shadow_pkg.sv
`include "shadow_cfg.svh"

package shadow_pkg;

    // one retired instruction as handed over by the model
    typedef struct packed {
        logic [`SHADOW_ORDER_W-1:0] order;
        logic [31:0]                insn;
        logic                       csr_we;
        logic [11:0]                csr_addr;
        logic [`SHADOW_XLEN-1:0]    csr_wdata;
        logic                       mem;
    } retire_rec_t;

    // stage register content
    typedef struct packed {
        retire_rec_t rec;
        logic        valid;
    } pipe_stage_t;

    // index into the irq vector
    typedef logic [4:0] irq_cause_t;

    // fill counter only has to reach depth-1
    typedef logic [$clog2(`SHADOW_PIPE_DEPTH)-1:0] fill_cnt_t;

    // outstanding accesses, zero up to the lsu depth
    typedef logic [$clog2(`SHADOW_LSU_DEPTH+1)-1:0] lsu_cnt_t;

endpackage

// File: src/step_ctrl.sv
`timescale 1ns/10ps
`include "shadow_cfg.svh"

module step_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic core_retire_i,
    input  logic flush_i,
    output logic step_o,
    output logic rec_ready_o,
    output logic pipe_full_o
);
    import shadow_pkg::*;

    localparam int FILL_STAGES = `SHADOW_PIPE_DEPTH - 1;

    fill_cnt_t fill_cnt_q;

    ////////////////////
    // fill tracking

    assign pipe_full_o = (fill_cnt_q == fill_cnt_t'(FILL_STAGES));

    // restart the fill after reset or any flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt_q <= '0;
        end else if (flush_i) begin
            fill_cnt_q <= '0;
        end else if (!pipe_full_o) begin
            fill_cnt_q <= fill_cnt_q + 1'b1;
        end
    end

    ////////////////////
    // step generation

    // free running while filling, then one step per core retirement
    // nothing moves in the flush cycle, so flushed records cannot reach WB
    assign step_o = !flush_i && (!pipe_full_o || core_retire_i);

    // a record is only accepted when the pipeline moves
    assign rec_ready_o = step_o;

endmodule

// File: src/shadow_pipe.sv
`timescale 1ns/10ps
`include "shadow_cfg.svh"

module shadow_pipe (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       step_i,
    input  logic                       flush_i,
    input  logic                       rec_valid_i,
    input  shadow_pkg::retire_rec_t    rec_i,
    output shadow_pkg::pipe_stage_t    id_ex_o,
    output shadow_pkg::pipe_stage_t    ex_wb_o,
    output logic                       out_valid_o,
    output logic [`SHADOW_ORDER_W-1:0] out_order_o,
    output logic [31:0]                out_insn_o
);
    import shadow_pkg::*;

    localparam int DEPTH  = `SHADOW_PIPE_DEPTH;
    localparam int STG_IF = 0;
    localparam int STG_ID = 1;
    localparam int STG_WB = DEPTH - 1;
    localparam int STG_EX = STG_WB - 1;

    logic [DEPTH-1:0] vld_q;
    retire_rec_t      rec_q [DEPTH];

    ////////////////////
    // stage valids

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            // flush only hits the front stages
            if (flush_i) begin
                vld_q[STG_WB-1:0] <= '0;
            end else if (step_i) begin
                vld_q[STG_WB-1:0] <= {vld_q[STG_WB-2:0], rec_valid_i};
            end
            // wb valid lives for the one cycle after a step
            vld_q[STG_WB] <= step_i && vld_q[STG_EX];
        end
    end

    ////////////////////
    // stage payload

    // bubbles carry stale data and only the valid bit counts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                rec_q[i] <= '0;
            end
        end else if (step_i) begin
            rec_q[STG_IF] <= rec_i;
            for (int i = 1; i < DEPTH; i++) begin
                rec_q[i] <= rec_q[i-1];
            end
        end
    end

    assign id_ex_o = '{rec: rec_q[STG_ID], valid: vld_q[STG_ID]};
    assign ex_wb_o = '{rec: rec_q[STG_EX], valid: vld_q[STG_EX]};

    assign out_valid_o = vld_q[STG_WB];
    assign out_order_o = rec_q[STG_WB].order;
    assign out_insn_o  = rec_q[STG_WB].insn;

    // a flushed EX record must never be stepped into WB
    a_no_step_on_flush: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush_i |-> !step_i
    ) else $error("step_i high during a flush");

endmodule

// File: src/csr_shadow.sv
`timescale 1ns/10ps
`include "shadow_cfg.svh"

module csr_shadow (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    step_i,
    input  logic                    intr_taken_i,
    input  shadow_pkg::pipe_stage_t ex_wb_i,
    output logic [`SHADOW_XLEN-1:0] mie_o,
    output logic                    intr_en_o
);

    logic csr_wr;
    logic mie_wr;
    logic gie_set;

    ////////////////////
    // csr decode

    // the ex_wb record is the one that retires at the next step
    assign csr_wr  = ex_wb_i.valid && ex_wb_i.rec.csr_we;
    assign mie_wr  = csr_wr && (ex_wb_i.rec.csr_addr == `SHADOW_CSR_MIE);
    assign gie_set = csr_wr && (ex_wb_i.rec.csr_addr == `SHADOW_CSR_MSTATUS)
                     && ex_wb_i.rec.csr_wdata[`SHADOW_MSTATUS_MIE_BIT];

    ////////////////////
    // shadow registers

    // mie as seen after writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_o <= '0;
        end else if (step_i && mie_wr) begin
            mie_o <= ex_wb_i.rec.csr_wdata;
        end
    end

    // global enable, dropped again once an interrupt is taken
    // the trap entry clears mstatus.mie in the core as well
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            intr_en_o <= 1'b0;
        end else if (intr_taken_i) begin
            intr_en_o <= 1'b0;
        end else if (step_i && gie_set) begin
            intr_en_o <= 1'b1;
        end
    end

endmodule

// File: src/lsu_tracker.sv
`timescale 1ns/10ps
`include "shadow_cfg.svh"

module lsu_tracker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    step_i,
    input  shadow_pkg::pipe_stage_t id_ex_i,
    input  logic                    mem_rsp_i,
    output logic                    lsu_idle_o
);
    import shadow_pkg::*;

    lsu_cnt_t cnt_q;
    logic     cnt_up;
    logic     cnt_down;

    // access is issued when a memory record steps into EX
    assign cnt_up   = step_i && id_ex_i.valid && id_ex_i.rec.mem;
    assign cnt_down = mem_rsp_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else begin
            case ({cnt_up, cnt_down})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // interrupts wait until every access has completed
    assign lsu_idle_o = (cnt_q == '0);

    a_lsu_cnt_max: assert property (
        @(posedge clk) disable iff (!rst_n)
        cnt_q <= lsu_cnt_t'(`SHADOW_LSU_DEPTH)
    ) else $error("more memory accesses outstanding than the lsu allows");

    a_lsu_no_orphan_rsp: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_rsp_i |-> (cnt_q != '0)
    ) else $error("memory response without an outstanding access");

endmodule

// File: src/irq_ctrl.sv
`timescale 1ns/10ps
`include "shadow_cfg.svh"

module irq_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`SHADOW_XLEN-1:0] irq_i,
    input  logic [`SHADOW_XLEN-1:0] mie_i,
    input  logic                    intr_en_i,
    input  logic                    lsu_idle_i,
    input  logic                    pipe_full_i,
    output logic                    intr_taken_o,
    output shadow_pkg::irq_cause_t  intr_cause_o
);
    import shadow_pkg::*;

    logic [`SHADOW_XLEN-1:0] irq_q;
    logic [`SHADOW_XLEN-1:0] irq_qq;
    logic [`SHADOW_XLEN-1:0] irq_pend;
    logic                    take_d;
    irq_cause_t              cause_d;

    ////////////////////
    // irq synchroniser

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q  <= '0;
            irq_qq <= '0;
        end else begin
            irq_q  <= irq_i;
            irq_qq <= irq_q;
        end
    end

    ////////////////////
    // take decision

    assign irq_pend = irq_qq & mie_i;

    // a pulse in flight blocks the next one and pipe_full drops after the flush
    assign take_d = (|irq_pend) && intr_en_i && lsu_idle_i && pipe_full_i
                    && !intr_taken_o;

    // lowest pending index wins
    always_comb begin
        cause_d = '0;
        for (int i = `SHADOW_XLEN - 1; i >= 0; i--) begin
            if (irq_pend[i]) begin
                cause_d = irq_cause_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            intr_taken_o <= 1'b0;
        end else begin
            intr_taken_o <= take_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            intr_cause_o <= '0;
        end else if (take_d) begin
            intr_cause_o <= cause_d;
        end
    end

endmodule

// File: src/shadow_top.sv
`timescale 1ns/10ps
`include "shadow_cfg.svh"

module shadow_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // upstream model
    input  logic                       rec_valid_i,
    output logic                       rec_ready_o,
    input  logic [`SHADOW_ORDER_W-1:0] rec_order_i,
    input  logic [31:0]                rec_insn_i,
    input  logic                       rec_csr_we_i,
    input  logic [11:0]                rec_csr_addr_i,
    input  logic [`SHADOW_XLEN-1:0]    rec_csr_wdata_i,
    input  logic                       rec_mem_i,
    // core side
    input  logic                       core_retire_i,
    input  logic                       mem_rsp_i,
    input  logic [`SHADOW_XLEN-1:0]    irq_i,
    // retire output
    output logic                       out_valid_o,
    output logic [`SHADOW_ORDER_W-1:0] out_order_o,
    output logic [31:0]                out_insn_o,
    // interrupt decision
    output logic                       intr_taken_o,
    output shadow_pkg::irq_cause_t     intr_cause_o
);
    import shadow_pkg::*;

    retire_rec_t             rec;
    pipe_stage_t             id_ex;
    pipe_stage_t             ex_wb;
    logic                    step;
    logic                    pipe_full;
    logic [`SHADOW_XLEN-1:0] mie;
    logic                    intr_en;
    logic                    lsu_idle;

    assign rec = '{
        order:     rec_order_i,
        insn:      rec_insn_i,
        csr_we:    rec_csr_we_i,
        csr_addr:  rec_csr_addr_i,
        csr_wdata: rec_csr_wdata_i,
        mem:       rec_mem_i
    };

    step_ctrl i_step (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_retire_i (core_retire_i),
        .flush_i       (intr_taken_o),
        .step_o        (step),
        .rec_ready_o   (rec_ready_o),
        .pipe_full_o   (pipe_full)
    );

    // a taken interrupt flushes the front stages
    shadow_pipe i_pipe (
        .clk         (clk),
        .rst_n       (rst_n),
        .step_i      (step),
        .flush_i     (intr_taken_o),
        .rec_valid_i (rec_valid_i),
        .rec_i       (rec),
        .id_ex_o     (id_ex),
        .ex_wb_o     (ex_wb),
        .out_valid_o (out_valid_o),
        .out_order_o (out_order_o),
        .out_insn_o  (out_insn_o)
    );

    csr_shadow i_csr (
        .clk          (clk),
        .rst_n        (rst_n),
        .step_i       (step),
        .intr_taken_i (intr_taken_o),
        .ex_wb_i      (ex_wb),
        .mie_o        (mie),
        .intr_en_o    (intr_en)
    );

    lsu_tracker i_lsu (
        .clk        (clk),
        .rst_n      (rst_n),
        .step_i     (step),
        .id_ex_i    (id_ex),
        .mem_rsp_i  (mem_rsp_i),
        .lsu_idle_o (lsu_idle)
    );

    irq_ctrl i_irq (
        .clk          (clk),
        .rst_n        (rst_n),
        .irq_i        (irq_i),
        .mie_i        (mie),
        .intr_en_i    (intr_en),
        .lsu_idle_i   (lsu_idle),
        .pipe_full_i  (pipe_full),
        .intr_taken_o (intr_taken_o),
        .intr_cause_o (intr_cause_o)
    );

endmodule

// File: tests/tb_clk.sv
`timescale 1ns/10ps

module tb_clk (
    output logic clk_o,
    output logic rst_n_o
);

    localparam time HALF_PERIOD = 20ns;
    localparam int  RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

    // release a little after the edge, like all other stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #5ns rst_n_o = 1'b1;
    end

endmodule

// File: tests/tb_top.sv
`timescale 1ns/10ps
`include "shadow_cfg.svh"

module tb_top;
    import shadow_pkg::*;

    localparam time         DRV_DLY        = 5ns;
    localparam int          ACCEPT_TIMEOUT = 50;
    localparam int          INTR_TIMEOUT   = 40;
    localparam int          RESET_TIMEOUT  = 20;
    localparam logic [31:0] IRQ_7_11       = 32'h0000_0880;

    typedef struct packed {
        logic [`SHADOW_ORDER_W-1:0] order;
        logic [31:0]                insn;
        logic                       csr_we;
        logic [11:0]                csr_addr;
        logic [`SHADOW_XLEN-1:0]    csr_wdata;
        logic                       mem;
        logic                       rsp;
        logic [`SHADOW_XLEN-1:0]    irq;
    } row_t;

    logic                       clk;
    logic                       rst_n;
    logic                       rec_valid;
    logic                       rec_ready;
    logic [`SHADOW_ORDER_W-1:0] rec_order;
    logic [31:0]                rec_insn;
    logic                       rec_csr_we;
    logic [11:0]                rec_csr_addr;
    logic [`SHADOW_XLEN-1:0]    rec_csr_wdata;
    logic                       rec_mem;
    logic                       core_retire;
    logic                       mem_rsp;
    logic [`SHADOW_XLEN-1:0]    irq;
    logic                       out_valid;
    logic [`SHADOW_ORDER_W-1:0] out_order;
    logic [31:0]                out_insn;
    logic                       intr_taken;
    irq_cause_t                 intr_cause;

    row_t                          rows[$];
    logic [`SHADOW_ORDER_W+31:0]   exp_q[$];
    int                            exp_step_q[$];
    int                            step_cnt;
    bit                            prev_step;
    int                            out_cnt;
    int                            intr_cnt;
    irq_cause_t                    last_cause;
    logic [`SHADOW_ORDER_W-1:0]    last_order;
    int                            waited;

    tb_clk i_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    shadow_top i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .rec_valid_i     (rec_valid),
        .rec_ready_o     (rec_ready),
        .rec_order_i     (rec_order),
        .rec_insn_i      (rec_insn),
        .rec_csr_we_i    (rec_csr_we),
        .rec_csr_addr_i  (rec_csr_addr),
        .rec_csr_wdata_i (rec_csr_wdata),
        .rec_mem_i       (rec_mem),
        .core_retire_i   (core_retire),
        .mem_rsp_i       (mem_rsp),
        .irq_i           (irq),
        .out_valid_o     (out_valid),
        .out_order_o     (out_order),
        .out_insn_o      (out_insn),
        .intr_taken_o    (intr_taken),
        .intr_cause_o    (intr_cause)
    );

    ////////////////////
    // reporting

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic fail_with(input string what);
        $display("ERROR at %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic check_eq(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED time=%0t %s got=%0h exp=%0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    ////////////////////
    // stimulus table

    function automatic row_t make_row(input logic [`SHADOW_ORDER_W-1:0] order,
                                      input logic [31:0] insn,
                                      input bit we, input logic [11:0] addr,
                                      input logic [31:0] wdata, input bit mem,
                                      input bit rsp, input logic [31:0] irq_val);
        row_t r;
        r.order     = order;
        r.insn      = insn;
        r.csr_we    = we;
        r.csr_addr  = addr;
        r.csr_wdata = wdata;
        r.mem       = mem;
        r.rsp       = rsp;
        r.irq       = irq_val;
        return r;
    endfunction

    task automatic build_table();
        // order, insn, csr_we, csr_addr, csr_wdata, mem, rsp, irq
        // 0..5 plain flow
        rows.push_back(make_row(1, 32'h0010_0093, 0, 12'h000, 0, 0, 0, 0));
        rows.push_back(make_row(2, 32'h0020_0113, 0, 12'h000, 0, 0, 0, 0));
        rows.push_back(make_row(3, 32'h0031_0193, 0, 12'h000, 0, 0, 0, 0));
        rows.push_back(make_row(4, 32'h0041_8213, 0, 12'h000, 0, 0, 0, 0));
        rows.push_back(make_row(5, 32'h0052_0293, 0, 12'h000, 0, 0, 0, 0));
        rows.push_back(make_row(6, 32'h0062_8313, 0, 12'h000, 0, 0, 0, 0));
        // 6..8 mie write with irq raised and the global enable still off
        rows.push_back(make_row(7, 32'h3040_9073, 1, 12'h304, IRQ_7_11, 0, 0, IRQ_7_11));
        rows.push_back(make_row(8, 32'h0073_0393, 0, 12'h000, 0, 0, 0, IRQ_7_11));
        rows.push_back(make_row(9, 32'h0083_8413, 0, 12'h000, 0, 0, 0, IRQ_7_11));
        // 9..14 mstatus.mie set and the interrupt flushes the front
        rows.push_back(make_row(10, 32'h3004_1073, 1, 12'h300, 32'h8, 0, 0, IRQ_7_11));
        rows.push_back(make_row(11, 32'h0094_0493, 0, 12'h000, 0, 0, 0, IRQ_7_11));
        rows.push_back(make_row(12, 32'h00a4_8513, 0, 12'h000, 0, 0, 0, IRQ_7_11));
        rows.push_back(make_row(13, 32'h00b5_0593, 0, 12'h000, 0, 0, 0, IRQ_7_11));
        rows.push_back(make_row(14, 32'h00c5_8613, 0, 12'h000, 0, 0, 0, IRQ_7_11));
        rows.push_back(make_row(15, 32'h00d6_0693, 0, 12'h000, 0, 0, 0, IRQ_7_11));
        // 15..18 enable again with a load outstanding
        rows.push_back(make_row(16, 32'h3004_1073, 1, 12'h300, 32'h8, 0, 0, IRQ_7_11));
        rows.push_back(make_row(17, 32'h0000_a703, 0, 12'h000, 0, 1, 0, IRQ_7_11));
        rows.push_back(make_row(18, 32'h00e6_8793, 0, 12'h000, 0, 0, 0, IRQ_7_11));
        rows.push_back(make_row(19, 32'h00f7_0813, 0, 12'h000, 0, 0, 1, IRQ_7_11));
        // 19..21 refill after the second interrupt
        rows.push_back(make_row(20, 32'h0107_8893, 0, 12'h000, 0, 0, 0, IRQ_7_11));
        rows.push_back(make_row(21, 32'h0118_0913, 0, 12'h000, 0, 0, 0, IRQ_7_11));
        rows.push_back(make_row(22, 32'h0128_8993, 0, 12'h000, 0, 0, 0, IRQ_7_11));
    endtask

    ////////////////////
    // driver tasks

    // the pending interrupt must wait for the memory response
    task automatic hold_then_respond();
        int seen;
        seen = intr_cnt;
        repeat (30) begin
            @(posedge clk);
            #DRV_DLY;
            check_eq("intr_taken_o count while lsu busy", intr_cnt, seen);
        end
        mem_rsp = 1'b1;
        @(posedge clk);
        #DRV_DLY;
        mem_rsp = 1'b0;
    endtask

    task automatic apply_row(input int r);
        int  gap;
        int  tries;
        bit  taken;
        rec_valid     = 1'b1;
        rec_order     = rows[r].order;
        rec_insn      = rows[r].insn;
        rec_csr_we    = rows[r].csr_we;
        rec_csr_addr  = rows[r].csr_addr;
        rec_csr_wdata = rows[r].csr_wdata;
        rec_mem       = rows[r].mem;
        irq           = rows[r].irq;
        gap   = $urandom_range(3, 0);
        taken = 1'b0;
        tries = 0;
        while (!taken) begin
            if (tries > ACCEPT_TIMEOUT) begin
                fail_with("record was not accepted by the shadow pipeline");
            end
            core_retire = (gap == 0);
            @(negedge clk);
            if (rec_ready) begin
                taken = 1'b1;
            end else if (gap > 0) begin
                gap--;
            end
            tries++;
            @(posedge clk);
            #DRV_DLY;
        end
        core_retire = 1'b0;
        if (rows[r].rsp) begin
            hold_then_respond();
        end
    endtask

    // push bubbles through so the last records reach the output
    task automatic retire_bubbles(input int n);
        int gap;
        rec_valid = 1'b0;
        for (int k = 0; k < n; k++) begin
            gap = $urandom_range(3, 0);
            repeat (gap) begin
                @(posedge clk);
                #DRV_DLY;
            end
            core_retire = 1'b1;
            @(posedge clk);
            #DRV_DLY;
            core_retire = 1'b0;
        end
        repeat (2) begin
            @(posedge clk);
            #DRV_DLY;
        end
    endtask

    task automatic wait_intr(input int target);
        int tries;
        tries = 0;
        while (intr_cnt < target) begin
            if (tries > INTR_TIMEOUT) begin
                fail_with("no interrupt was taken in time");
            end
            @(posedge clk);
            #DRV_DLY;
            tries++;
        end
    endtask

    ////////////////////
    // monitor

    // a record taken on step k leaves WB right after step k+3
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    fail_with("out_valid_o high with no record in flight");
                end else begin
                    check_eq("out_order_o", out_order, exp_q[0][`SHADOW_ORDER_W+31:32]);
                    check_eq("out_insn_o", out_insn, exp_q[0][31:0]);
                    check_eq("out_valid_o step index", step_cnt - 1, exp_step_q[0] + 3);
                    check_eq("step before out_valid_o", prev_step, 1);
                    last_order = out_order;
                    out_cnt++;
                    void'(exp_q.pop_front());
                    void'(exp_step_q.pop_front());
                end
            end else if (prev_step && exp_step_q.size() > 0
                         && exp_step_q[0] + 3 == step_cnt - 1) begin
                fail_with("record missing at the output after its third step");
            end
            // IF, ID and EX are dropped at the pulse
            if (intr_taken) begin
                intr_cnt++;
                last_cause = intr_cause;
                check_eq("rec_ready_o during flush", rec_ready, 0);
                exp_q.delete();
                exp_step_q.delete();
            end
            prev_step = rec_ready;
            if (rec_ready) begin
                if (rec_valid) begin
                    exp_q.push_back({rec_order, rec_insn});
                    exp_step_q.push_back(step_cnt);
                end
                step_cnt++;
            end
        end
    end

    initial begin
        #2ms;
        fail_with("simulation ran past its time limit");
    end

    ////////////////////
    // main sequence

    initial begin
        void'($urandom(32'h91c3_0d02));
        rec_valid     = 1'b0;
        rec_order     = '0;
        rec_insn      = '0;
        rec_csr_we    = 1'b0;
        rec_csr_addr  = '0;
        rec_csr_wdata = '0;
        rec_mem       = 1'b0;
        core_retire   = 1'b0;
        mem_rsp       = 1'b0;
        irq           = '0;
        step_cnt      = 0;
        prev_step     = 1'b0;
        out_cnt       = 0;
        intr_cnt      = 0;
        build_table();

        waited = 0;
        @(negedge clk);
        while (!rst_n) begin
            if (waited > RESET_TIMEOUT) begin
                fail_with("reset was never released");
            end
            waited++;
            @(negedge clk);
        end
        check_eq("out_valid_o after reset", out_valid, 0);
        check_eq("intr_taken_o after reset", intr_taken, 0);
        // three free steps to fill IF, ID and EX
        for (int k = 0; k < `SHADOW_PIPE_DEPTH - 1; k++) begin
            check_eq("rec_ready_o during fill", rec_ready, 1);
            @(negedge clk);
        end
        check_eq("rec_ready_o after fill", rec_ready, 0);
        @(posedge clk);
        #DRV_DLY;

        for (int r = 0; r < 6; r++) begin
            apply_row(r);
        end
        retire_bubbles(4);
        check_eq("outputs of in-order flow", out_cnt, 6);
        check_eq("records left in flight", exp_q.size(), 0);

        for (int r = 6; r < 9; r++) begin
            apply_row(r);
        end
        retire_bubbles(4);
        repeat (40) @(posedge clk);
        #DRV_DLY;
        check_eq("interrupts without global enable", intr_cnt, 0);

        for (int r = 9; r < 15; r++) begin
            apply_row(r);
        end
        wait_intr(1);
        retire_bubbles(4);
        check_eq("interrupts after enable", intr_cnt, 1);
        check_eq("intr_cause_o", last_cause, 7);
        check_eq("last order after refill", last_order, rows[14].order);
        check_eq("records left in flight", exp_q.size(), 0);

        for (int r = 15; r < 19; r++) begin
            apply_row(r);
        end
        wait_intr(2);
        check_eq("intr_cause_o after lsu response", last_cause, 7);
        for (int r = 19; r < 22; r++) begin
            apply_row(r);
        end
        retire_bubbles(4);
        check_eq("interrupts in total", intr_cnt, 2);
        check_eq("last order at end", last_order, rows[21].order);
        check_eq("records left in flight", exp_q.size(), 0);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+src
src/shadow_pkg.sv
src/step_ctrl.sv
src/shadow_pipe.sv
src/csr_shadow.sv
src/lsu_tracker.sv
src/irq_ctrl.sv
src/shadow_top.sv
tests/tb_clk.sv
tests/tb_top.sv
